/* design/accel_csr_pkg.sv */
// ==================================================
// Register map of the accelerator CSR block
// Byte offsets are 8 bits, every register is 32 bits
// Scale registers hold raw float32 patterns only
// ==================================================
package accel_csr_pkg;

        // Word types
        typedef logic [31:0] csr_word_t;
        typedef logic [31:0] dim_t;
        typedef logic [31:0] fp32_bits_t;
        typedef logic [31:0] dma_addr_t;

        // ==================================================
        // Register offsets
        // ==================================================
        localparam logic [7:0] OFS_CTRL     = 8'h00;
        localparam logic [7:0] OFS_DIMS_M   = 8'h04;
        localparam logic [7:0] OFS_DIMS_N   = 8'h08;
        localparam logic [7:0] OFS_DIMS_K   = 8'h0C;
        localparam logic [7:0] OFS_TILE_M   = 8'h10;
        localparam logic [7:0] OFS_TILE_N   = 8'h14;
        localparam logic [7:0] OFS_TILE_K   = 8'h18;
        localparam logic [7:0] OFS_SCALE_A  = 8'h2C;
        localparam logic [7:0] OFS_SCALE_W  = 8'h30;
        localparam logic [7:0] OFS_STATUS   = 8'h3C;
        localparam logic [7:0] OFS_DMA_SRC  = 8'h90;
        localparam logic [7:0] OFS_DMA_DST  = 8'h94;
        localparam logic [7:0] OFS_DMA_LEN  = 8'h98;
        localparam logic [7:0] OFS_DMA_CTRL = 8'h9C;

        // Bit positions inside the control and status words
        localparam int unsigned CTRL_START_BIT     = 0;
        localparam int unsigned CTRL_ABORT_BIT     = 1;
        localparam int unsigned CTRL_IRQ_EN_BIT    = 2;
        localparam int unsigned STATUS_BUSY_BIT    = 0;
        localparam int unsigned STATUS_DONE_BIT    = 1;
        localparam int unsigned STATUS_ILLEGAL_BIT = 9;
        localparam int unsigned DMA_START_BIT      = 0;
        localparam int unsigned DMA_BUSY_BIT       = 1;
        localparam int unsigned DMA_DONE_BIT       = 2;

        // float32 1.0
        localparam fp32_bits_t SCALE_ONE     = 32'h3F80_0000;
        localparam csr_word_t  UNMAPPED_WORD = 32'hDEAD_BEEF;

        // ==================================================
        // Shared structs
        // ==================================================
        // One select bit per register, plus a flag for a strobe that hits nothing
        typedef struct packed {
                logic ctrl;
                logic dims_m;
                logic dims_n;
                logic dims_k;
                logic tile_m;
                logic tile_n;
                logic tile_k;
                logic scale_a;
                logic scale_w;
                logic status;
                logic dma_src;
                logic dma_dst;
                logic dma_len;
                logic dma_ctrl;
                logic unmapped;
        } reg_sel_t;

        typedef struct packed {
                dim_t       m;
                dim_t       n;
                dim_t       k;
                dim_t       tm;
                dim_t       tn;
                dim_t       tk;
                fp32_bits_t scale_a;
                fp32_bits_t scale_w;
        } core_cfg_t;

        typedef struct packed {
                logic irq_en;
                logic done_tile;
                logic err_illegal;
        } core_status_t;

        typedef struct packed {
                dma_addr_t src;
                dma_addr_t dst;
                csr_word_t len;
        } dma_cfg_t;

        typedef struct packed {
                logic done;
        } dma_status_t;

        // Reset image of the core configuration
        localparam core_cfg_t CORE_CFG_RST = '{
                m: '0, n: '0, k: '0,
                tm: '0, tn: '0, tk: '0,
                scale_a: SCALE_ONE, scale_w: SCALE_ONE
        };

endpackage

/* design/csr_addr_decode.sv */
// ==================================================
// Combinational address decoder
// Address bits above bit 7 must be zero to match
// ==================================================
`timescale 1ns/1ps

module csr_addr_decode #(
        parameter int unsigned ADDR_W = 8
) (
        input  logic                  csr_wen,
        input  logic                  csr_ren,
        input  logic [ADDR_W-1:0]     csr_addr,
        output accel_csr_pkg::reg_sel_t wr_sel,
        output accel_csr_pkg::reg_sel_t rd_sel
);
        import accel_csr_pkg::*;

        logic       upper_zero;
        logic [7:0] ofs;
        logic       any_hit;
        reg_sel_t   hit;

        assign upper_zero = ((csr_addr >> 8) == '0);
        assign ofs        = csr_addr[7:0];

        // One-hot match against the map
        always_comb begin
                hit = '0;
                if (upper_zero) begin
                        case (ofs)
                                OFS_CTRL:     hit.ctrl     = 1'b1;
                                OFS_DIMS_M:   hit.dims_m   = 1'b1;
                                OFS_DIMS_N:   hit.dims_n   = 1'b1;
                                OFS_DIMS_K:   hit.dims_k   = 1'b1;
                                OFS_TILE_M:   hit.tile_m   = 1'b1;
                                OFS_TILE_N:   hit.tile_n   = 1'b1;
                                OFS_TILE_K:   hit.tile_k   = 1'b1;
                                OFS_SCALE_A:  hit.scale_a  = 1'b1;
                                OFS_SCALE_W:  hit.scale_w  = 1'b1;
                                OFS_STATUS:   hit.status   = 1'b1;
                                OFS_DMA_SRC:  hit.dma_src  = 1'b1;
                                OFS_DMA_DST:  hit.dma_dst  = 1'b1;
                                OFS_DMA_LEN:  hit.dma_len  = 1'b1;
                                OFS_DMA_CTRL: hit.dma_ctrl = 1'b1;
                                default:      ;
                        endcase
                end
                any_hit      = |hit;
                hit.unmapped = ~any_hit;
        end

        // Qualify by the strobes
        // Only a read reports a miss through the unmapped flag
        always_comb begin
                wr_sel          = csr_wen ? hit : '0;
                wr_sel.unmapped = 1'b0;
        end

        assign rd_sel = csr_ren ? hit : '0;

endmodule

/* design/core_ctrl_regs.sv */
// ==================================================
// Core configuration, start guard and sticky status
// Start is refused while busy or with a zero tile
// A sticky set wins over a same-cycle write-1 clear
// ==================================================
`timescale 1ns/1ps

module core_ctrl_regs (
        input  logic                        clk_gated,
        input  logic                        rst_n,
        input  accel_csr_pkg::reg_sel_t     wr_sel,
        input  accel_csr_pkg::csr_word_t    csr_wdata,
        input  logic                        core_busy,
        input  logic                        core_done_tile_pulse,
        input  logic                        rx_illegal_cmd,
        output logic                        start_pulse,
        output logic                        abort_pulse,
        output accel_csr_pkg::core_cfg_t    core_cfg,
        output accel_csr_pkg::core_status_t core_status
);
        import accel_csr_pkg::*;

        logic start_req;
        logic tiles_ok;
        logic start_blocked;
        logic clr_done;
        logic clr_illegal;

        // ==================================================
        // Control pulses
        // ==================================================
        assign start_req     = wr_sel.ctrl & csr_wdata[CTRL_START_BIT];
        assign tiles_ok      = (core_cfg.tm != '0) && (core_cfg.tn != '0) && (core_cfg.tk != '0);
        assign start_pulse   = start_req & ~core_busy & tiles_ok;
        assign start_blocked = start_req & (core_busy | ~tiles_ok);
        // Abort is never guarded
        assign abort_pulse   = wr_sel.ctrl & csr_wdata[CTRL_ABORT_BIT];

        // Write-1 clears from STATUS
        assign clr_done    = wr_sel.status & csr_wdata[STATUS_DONE_BIT];
        assign clr_illegal = wr_sel.status & csr_wdata[STATUS_ILLEGAL_BIT];

        // ==================================================
        // Configuration registers
        // ==================================================
        always_ff @(posedge clk_gated or negedge rst_n) begin
                if (!rst_n) begin
                        core_cfg <= CORE_CFG_RST;
                end else begin
                        if (wr_sel.dims_m) begin
                                core_cfg.m <= csr_wdata;
                        end
                        if (wr_sel.dims_n) begin
                                core_cfg.n <= csr_wdata;
                        end
                        if (wr_sel.dims_k) begin
                                core_cfg.k <= csr_wdata;
                        end
                        if (wr_sel.tile_m) begin
                                core_cfg.tm <= csr_wdata;
                        end
                        if (wr_sel.tile_n) begin
                                core_cfg.tn <= csr_wdata;
                        end
                        if (wr_sel.tile_k) begin
                                core_cfg.tk <= csr_wdata;
                        end
                        if (wr_sel.scale_a) begin
                                core_cfg.scale_a <= csr_wdata;
                        end
                        if (wr_sel.scale_w) begin
                                core_cfg.scale_w <= csr_wdata;
                        end
                end
        end

        // ==================================================
        // irq_en and sticky bits
        // ==================================================
        always_ff @(posedge clk_gated or negedge rst_n) begin
                if (!rst_n) begin
                        core_status <= '0;
                end else begin
                        if (wr_sel.ctrl) begin
                                core_status.irq_en <= csr_wdata[CTRL_IRQ_EN_BIT];
                        end
                        if (core_done_tile_pulse) begin
                                core_status.done_tile <= 1'b1;
                        end else if (clr_done) begin
                                core_status.done_tile <= 1'b0;
                        end
                        // Blocked start and bad command share one flag
                        if (rx_illegal_cmd || start_blocked) begin
                                core_status.err_illegal <= 1'b1;
                        end else if (clr_illegal) begin
                                core_status.err_illegal <= 1'b0;
                        end
                end
        end

endmodule

/* design/dma_ctrl_regs.sv */
// ==================================================
// Weight DMA channel registers
// Start is a write-1 pulse with no busy guard
// ==================================================
`timescale 1ns/1ps

module dma_ctrl_regs (
        input  logic                       clk_gated,
        input  logic                       rst_n,
        input  accel_csr_pkg::reg_sel_t    wr_sel,
        input  accel_csr_pkg::csr_word_t   csr_wdata,
        input  logic                       dma_done,
        output logic                       dma_start_pulse,
        output accel_csr_pkg::dma_cfg_t    dma_cfg,
        output accel_csr_pkg::dma_status_t dma_status
);
        import accel_csr_pkg::*;

        logic clr_done;

        assign dma_start_pulse = wr_sel.dma_ctrl & csr_wdata[DMA_START_BIT];
        assign clr_done        = wr_sel.dma_ctrl & csr_wdata[DMA_DONE_BIT];

        // Source, destination and length
        always_ff @(posedge clk_gated or negedge rst_n) begin
                if (!rst_n) begin
                        dma_cfg <= '0;
                end else begin
                        if (wr_sel.dma_src) begin
                                dma_cfg.src <= csr_wdata;
                        end
                        if (wr_sel.dma_dst) begin
                                dma_cfg.dst <= csr_wdata;
                        end
                        if (wr_sel.dma_len) begin
                                dma_cfg.len <= csr_wdata;
                        end
                end
        end

        // Sticky done bit where the engine event wins over a clear
        always_ff @(posedge clk_gated or negedge rst_n) begin
                if (!rst_n) begin
                        dma_status <= '0;
                end else if (dma_done) begin
                        dma_status.done <= 1'b1;
                end else if (clr_done) begin
                        dma_status.done <= 1'b0;
                end
        end

endmodule

/* design/csr_read_mux.sv */
// ==================================================
// Registered read path
// Data and rvalid appear one cycle after the strobe
// Unused bits read as zero
// ==================================================
`timescale 1ns/1ps

module csr_read_mux (
        input  logic                        clk_gated,
        input  logic                        rst_n,
        input  accel_csr_pkg::reg_sel_t     rd_sel,
        input  accel_csr_pkg::core_cfg_t    core_cfg,
        input  accel_csr_pkg::core_status_t core_status,
        input  logic                        core_busy,
        input  accel_csr_pkg::dma_cfg_t     dma_cfg,
        input  accel_csr_pkg::dma_status_t  dma_status,
        input  logic                        dma_busy,
        output accel_csr_pkg::csr_word_t    csr_rdata,
        output logic                        csr_rvalid
);
        import accel_csr_pkg::*;

        logic      rd_active;
        csr_word_t rd_word;

        // The unmapped flag keeps a miss visible as an active read
        assign rd_active = |rd_sel;

        // Selects are one-hot, so each branch stands alone
        always_comb begin
                rd_word = '0;
                if (rd_sel.ctrl) begin
                        rd_word[CTRL_IRQ_EN_BIT] = core_status.irq_en;
                end
                if (rd_sel.dims_m)  rd_word = core_cfg.m;
                if (rd_sel.dims_n)  rd_word = core_cfg.n;
                if (rd_sel.dims_k)  rd_word = core_cfg.k;
                if (rd_sel.tile_m)  rd_word = core_cfg.tm;
                if (rd_sel.tile_n)  rd_word = core_cfg.tn;
                if (rd_sel.tile_k)  rd_word = core_cfg.tk;
                if (rd_sel.scale_a) rd_word = core_cfg.scale_a;
                if (rd_sel.scale_w) rd_word = core_cfg.scale_w;
                if (rd_sel.status) begin
                        rd_word[STATUS_BUSY_BIT]    = core_busy;
                        rd_word[STATUS_DONE_BIT]    = core_status.done_tile;
                        rd_word[STATUS_ILLEGAL_BIT] = core_status.err_illegal;
                end
                if (rd_sel.dma_src) rd_word = dma_cfg.src;
                if (rd_sel.dma_dst) rd_word = dma_cfg.dst;
                if (rd_sel.dma_len) rd_word = dma_cfg.len;
                if (rd_sel.dma_ctrl) begin
                        rd_word[DMA_BUSY_BIT] = dma_busy;
                        rd_word[DMA_DONE_BIT] = dma_status.done;
                end
                if (rd_sel.unmapped) rd_word = UNMAPPED_WORD;
        end

        // Data holds between reads
        always_ff @(posedge clk_gated or negedge rst_n) begin
                if (!rst_n) begin
                        csr_rdata  <= '0;
                        csr_rvalid <= 1'b0;
                end else begin
                        csr_rvalid <= rd_active;
                        if (rd_active) begin
                                csr_rdata <= rd_word;
                        end
                end
        end

endmodule

/* design/accel_csr_top.sv */
// ==================================================
// CSR block of the matrix accelerator
// Expects an already gated clock and a strobe bus
// with no back-pressure, reads return one cycle late
// ==================================================
`timescale 1ns/1ps

module accel_csr_top #(
        parameter int unsigned ADDR_W = 8
) (
        input  logic                     clk_gated,
        input  logic                     rst_n,
        // Host bus
        input  logic                     csr_wen,
        input  logic                     csr_ren,
        input  logic [ADDR_W-1:0]        csr_addr,
        input  accel_csr_pkg::csr_word_t csr_wdata,
        output accel_csr_pkg::csr_word_t csr_rdata,
        output logic                     csr_rvalid,
        // Core side
        input  logic                     core_busy,
        input  logic                     core_done_tile_pulse,
        input  logic                     rx_illegal_cmd,
        // DMA side
        input  logic                     dma_busy,
        input  logic                     dma_done,
        // Configuration out
        output logic                     start_pulse,
        output logic                     abort_pulse,
        output logic                     irq_en,
        output accel_csr_pkg::core_cfg_t core_cfg,
        output logic                     dma_start_pulse,
        output accel_csr_pkg::dma_cfg_t  dma_cfg
);
        import accel_csr_pkg::*;

        reg_sel_t     wr_sel;
        reg_sel_t     rd_sel;
        core_status_t core_status;
        dma_status_t  dma_status;

        assign irq_en = core_status.irq_en;

        csr_addr_decode #(
                .ADDR_W (ADDR_W)
        ) u_decode (
                .csr_wen  (csr_wen),
                .csr_ren  (csr_ren),
                .csr_addr (csr_addr),
                .wr_sel   (wr_sel),
                .rd_sel   (rd_sel)
        );

        core_ctrl_regs u_core_regs (
                .clk_gated            (clk_gated),
                .rst_n                (rst_n),
                .wr_sel               (wr_sel),
                .csr_wdata            (csr_wdata),
                .core_busy            (core_busy),
                .core_done_tile_pulse (core_done_tile_pulse),
                .rx_illegal_cmd       (rx_illegal_cmd),
                .start_pulse          (start_pulse),
                .abort_pulse          (abort_pulse),
                .core_cfg             (core_cfg),
                .core_status          (core_status)
        );

        dma_ctrl_regs u_dma_regs (
                .clk_gated       (clk_gated),
                .rst_n           (rst_n),
                .wr_sel          (wr_sel),
                .csr_wdata       (csr_wdata),
                .dma_done        (dma_done),
                .dma_start_pulse (dma_start_pulse),
                .dma_cfg         (dma_cfg),
                .dma_status      (dma_status)
        );

        csr_read_mux u_read_mux (
                .clk_gated   (clk_gated),
                .rst_n       (rst_n),
                .rd_sel      (rd_sel),
                .core_cfg    (core_cfg),
                .core_status (core_status),
                .core_busy   (core_busy),
                .dma_cfg     (dma_cfg),
                .dma_status  (dma_status),
                .dma_busy    (dma_busy),
                .csr_rdata   (csr_rdata),
                .csr_rvalid  (csr_rvalid)
        );

endmodule

/* sim/tb_clock_gen.sv */
// ==================================================
// Testbench clock and reset
// 20 ns period, reset held low for 16 cycles
// ==================================================
`timescale 1ns/1ps

module tb_clock_gen (
        output logic clk_gated,
        output logic rst_n
);
        initial begin
                clk_gated = 1'b0;
                forever #10 clk_gated = ~clk_gated;
        end

        // Release on a falling edge, away from the sampling edge
        initial begin
                rst_n = 1'b0;
                repeat (16) @(posedge clk_gated);
                @(negedge clk_gated);
                rst_n = 1'b1;
        end

endmodule

/* sim/tb_accel_csr.sv */
// ==================================================
// Testbench for the accelerator CSR block
// A cycle model of the register map runs beside the DUT
// ==================================================
`timescale 1ns/1ps

module tb_accel_csr;
        import accel_csr_pkg::*;

        logic clk_gated, rst_n, csr_wen, csr_ren, csr_rvalid;
        logic [7:0] csr_addr;
        csr_word_t csr_wdata, csr_rdata;
        logic core_busy, core_done_tile_pulse, rx_illegal_cmd, dma_busy, dma_done;
        logic start_pulse, abort_pulse, irq_en, dma_start_pulse;
        core_cfg_t core_cfg;
        dma_cfg_t  dma_cfg;

        // Reference model state
        csr_word_t mdl [0:255];
        logic m_irq, m_done_tile, m_illegal, m_dma_done;
        logic exp_rvalid_q;
        csr_word_t exp_rdata_q;
        int errs = 0;
        int pass_cnt = 0;
        int fail_cnt = 0;

        tb_clock_gen clk_gen (.clk_gated(clk_gated), .rst_n(rst_n));

        accel_csr_top #(.ADDR_W(8)) uut (
                .clk_gated(clk_gated), .rst_n(rst_n), .csr_wen(csr_wen), .csr_ren(csr_ren),
                .csr_addr(csr_addr), .csr_wdata(csr_wdata), .csr_rdata(csr_rdata),
                .csr_rvalid(csr_rvalid), .core_busy(core_busy),
                .core_done_tile_pulse(core_done_tile_pulse), .rx_illegal_cmd(rx_illegal_cmd),
                .dma_busy(dma_busy), .dma_done(dma_done), .start_pulse(start_pulse),
                .abort_pulse(abort_pulse), .irq_en(irq_en), .core_cfg(core_cfg),
                .dma_start_pulse(dma_start_pulse), .dma_cfg(dma_cfg)
        );

        task automatic report_value(input string name, input logic [255:0] exp,
                                    input logic [255:0] got);
                $display("ERR %s expected %h actual %h", name, exp, got);
                errs++;
        endtask

        task automatic report_text(input string msg);
                $display("%s", msg);
                errs++;
        endtask

        // Plain data registers that read back what was written
        function automatic logic is_data_reg(input logic [7:0] ofs);
                case (ofs)
                        OFS_DIMS_M, OFS_DIMS_N, OFS_DIMS_K, OFS_TILE_M, OFS_TILE_N,
                        OFS_TILE_K, OFS_SCALE_A, OFS_SCALE_W, OFS_DMA_SRC, OFS_DMA_DST,
                        OFS_DMA_LEN: return 1'b1;
                        default: return 1'b0;
                endcase
        endfunction

        // Expected read word from the model state before this cycle's write
        function automatic csr_word_t model_read(input logic [7:0] ofs);
                csr_word_t w;
                w = '0;
                case (ofs)
                        OFS_CTRL: w[2] = m_irq;
                        OFS_STATUS: begin
                                w[0] = core_busy;
                                w[1] = m_done_tile;
                                w[9] = m_illegal;
                        end
                        OFS_DMA_CTRL: begin
                                w[1] = dma_busy;
                                w[2] = m_dma_done;
                        end
                        default: w = is_data_reg(ofs) ? mdl[ofs] : UNMAPPED_WORD;
                endcase
                return w;
        endfunction

        // ==================================================
        // Checker and model update on every rising edge
        // ==================================================
        always @(posedge clk_gated) begin
                logic exp_start, exp_abort, exp_dstart, tiles_ok, ctrl_wr;
                core_cfg_t exp_cfg;
                dma_cfg_t exp_dma;
                if (!rst_n) begin
                        for (int i = 0; i < 256; i++) mdl[i] = '0;
                        mdl[OFS_SCALE_A] = 32'h3F80_0000;
                        mdl[OFS_SCALE_W] = 32'h3F80_0000;
                        {m_irq, m_done_tile, m_illegal, m_dma_done} = '0;
                        exp_rvalid_q <= 1'b0;
                        exp_rdata_q  <= '0;
                end else begin
                        ctrl_wr    = csr_wen && csr_addr == OFS_CTRL;
                        tiles_ok   = mdl[OFS_TILE_M] != 0 && mdl[OFS_TILE_N] != 0 &&
                                     mdl[OFS_TILE_K] != 0;
                        exp_start  = ctrl_wr && csr_wdata[0] && !core_busy && tiles_ok;
                        exp_abort  = ctrl_wr && csr_wdata[1];
                        exp_dstart = csr_wen && csr_addr == OFS_DMA_CTRL && csr_wdata[0];
                        exp_cfg = '{m: mdl[OFS_DIMS_M], n: mdl[OFS_DIMS_N], k: mdl[OFS_DIMS_K],
                                    tm: mdl[OFS_TILE_M], tn: mdl[OFS_TILE_N],
                                    tk: mdl[OFS_TILE_K], scale_a: mdl[OFS_SCALE_A],
                                    scale_w: mdl[OFS_SCALE_W]};
                        exp_dma = '{src: mdl[OFS_DMA_SRC], dst: mdl[OFS_DMA_DST],
                                    len: mdl[OFS_DMA_LEN]};
                        assert (start_pulse == exp_start)
                        else report_value("start_pulse", 256'(exp_start), 256'(start_pulse));
                        assert (abort_pulse == exp_abort)
                        else report_value("abort_pulse", 256'(exp_abort), 256'(abort_pulse));
                        assert (dma_start_pulse == exp_dstart)
                        else report_value("dma_start_pulse", 256'(exp_dstart),
                                          256'(dma_start_pulse));
                        assert (csr_rvalid == exp_rvalid_q)
                        else report_value("csr_rvalid", 256'(exp_rvalid_q), 256'(csr_rvalid));
                        assert (!exp_rvalid_q || csr_rdata == exp_rdata_q)
                        else report_value("csr_rdata", 256'(exp_rdata_q), 256'(csr_rdata));
                        assert (irq_en == m_irq)
                        else report_value("irq_en", 256'(m_irq), 256'(irq_en));
                        assert (core_cfg == exp_cfg)
                        else report_value("core_cfg", exp_cfg, core_cfg);
                        assert (dma_cfg == exp_dma)
                        else report_value("dma_cfg", 256'(exp_dma), 256'(dma_cfg));
                        exp_rvalid_q <= csr_ren;
                        if (csr_ren) exp_rdata_q <= model_read(csr_addr);
                        // Apply this cycle's write first so that the events below win
                        if (csr_wen) begin
                                if (is_data_reg(csr_addr)) mdl[csr_addr] = csr_wdata;
                                if (ctrl_wr) m_irq = csr_wdata[2];
                                if (csr_addr == OFS_STATUS && csr_wdata[1]) m_done_tile = 1'b0;
                                if (csr_addr == OFS_STATUS && csr_wdata[9]) m_illegal = 1'b0;
                                if (csr_addr == OFS_DMA_CTRL && csr_wdata[2]) m_dma_done = 1'b0;
                        end
                        if (core_done_tile_pulse) m_done_tile = 1'b1;
                        if (rx_illegal_cmd || (ctrl_wr && csr_wdata[0] && !exp_start))
                                m_illegal = 1'b1;
                        if (dma_done) m_dma_done = 1'b1;
                end
        end

        // ==================================================
        // Bus and event drivers on the falling edge
        // ==================================================
        task automatic wait_rvalid();
                int n;
                n = 0;
                while (!csr_rvalid && n < 4) begin
                        @(negedge clk_gated);
                        n++;
                end
                if (!csr_rvalid) report_text("read got no csr_rvalid within 4 cycles");
        endtask

        task automatic write_reg(input logic [7:0] a, input csr_word_t d);
                @(negedge clk_gated);
                {csr_wen, csr_addr, csr_wdata} = {1'b1, a, d};
                @(negedge clk_gated);
                csr_wen = 1'b0;
        endtask

        task automatic read_reg(input logic [7:0] a);
                @(negedge clk_gated);
                {csr_ren, csr_addr} = {1'b1, a};
                @(negedge clk_gated);
                csr_ren = 1'b0;
                wait_rvalid();
        endtask

        task automatic write_read_same(input logic [7:0] a, input csr_word_t d);
                @(negedge clk_gated);
                {csr_wen, csr_ren, csr_addr, csr_wdata} = {2'b11, a, d};
                @(negedge clk_gated);
                {csr_wen, csr_ren} = 2'b00;
                wait_rvalid();
        endtask

        task automatic pulse_event(input int which);
                @(negedge clk_gated);
                core_done_tile_pulse = (which == 0);
                rx_illegal_cmd = (which == 1);
                dma_done = (which == 2);
                @(negedge clk_gated);
                {core_done_tile_pulse, rx_illegal_cmd, dma_done} = '0;
        endtask

        task automatic finish_test(input int num, input string name, input int errs_before);
                if (errs == errs_before) begin
                        $display("test %0d %s: passed", num, name);
                        pass_cnt++;
                end else begin
                        $display("test %0d %s: failed, %0d errors", num, name, errs - errs_before);
                        fail_cnt++;
                end
        endtask

        // Watchdog sized for 6 tests of at most 2000 cycles each
        initial begin
                #(6 * 2000 * 20);
                $display("watchdog expired before the tests finished");
                $display("** FAIL **");
                $finish;
        end

        initial begin
                logic [7:0] ofs_list [11];
                int e0;
                ofs_list = '{OFS_DIMS_M, OFS_DIMS_N, OFS_DIMS_K, OFS_TILE_M,
                        OFS_TILE_N, OFS_TILE_K, OFS_SCALE_A, OFS_SCALE_W, OFS_DMA_SRC,
                        OFS_DMA_DST, OFS_DMA_LEN};
                void'($urandom(43));
                {csr_wen, csr_ren, csr_addr, csr_wdata} = '0;
                {core_busy, core_done_tile_pulse, rx_illegal_cmd, dma_busy, dma_done} = '0;
                @(posedge rst_n);

                e0 = errs;
                @(negedge clk_gated);
                assert (csr_rdata == '0)
                else report_value("csr_rdata", '0, 256'(csr_rdata));
                // Back-to-back burst over the map plus an unmapped offset
                foreach (ofs_list[i]) begin
                        @(negedge clk_gated);
                        {csr_ren, csr_addr} = {1'b1, ofs_list[i]};
                end
                @(negedge clk_gated);
                csr_addr = OFS_STATUS;
                @(negedge clk_gated);
                csr_addr = OFS_DMA_CTRL;
                @(negedge clk_gated);
                csr_addr = 8'h40;
                @(negedge clk_gated);
                csr_ren = 1'b0;
                read_reg(OFS_CTRL);
                finish_test(1, "reset defaults", e0);

                e0 = errs;
                foreach (ofs_list[i]) write_reg(ofs_list[i], $urandom | 32'h1);
                foreach (ofs_list[i]) read_reg(ofs_list[i]);
                write_reg(OFS_CTRL, 32'h7);
                read_reg(OFS_CTRL);
                finish_test(2, "write and readback", e0);

                e0 = errs;
                write_reg(OFS_TILE_K, 32'h0);
                write_reg(OFS_CTRL, 32'h1);
                read_reg(OFS_STATUS);
                write_reg(OFS_STATUS, 32'h200);
                write_reg(OFS_TILE_K, 32'h8);
                core_busy = 1'b1;
                write_reg(OFS_CTRL, 32'h3);
                read_reg(OFS_STATUS);
                core_busy = 1'b0;
                write_reg(OFS_STATUS, 32'h200);
                write_reg(OFS_CTRL, 32'h5);
                write_reg(OFS_CTRL, 32'h2);
                read_reg(OFS_STATUS);
                finish_test(3, "start guard and abort", e0);

                e0 = errs;
                pulse_event(0);
                pulse_event(1);
                read_reg(OFS_STATUS);
                write_reg(OFS_STATUS, 32'h0);
                read_reg(OFS_STATUS);
                write_reg(OFS_STATUS, 32'h2);
                read_reg(OFS_STATUS);
                write_reg(OFS_STATUS, 32'h200);
                core_busy = 1'b1;
                read_reg(OFS_STATUS);
                core_busy = 1'b0;
                finish_test(4, "core sticky status", e0);

                e0 = errs;
                write_reg(OFS_DMA_CTRL, 32'h1);
                pulse_event(2);
                dma_busy = 1'b1;
                read_reg(OFS_DMA_CTRL);
                write_reg(OFS_DMA_CTRL, 32'h0);
                read_reg(OFS_DMA_CTRL);
                write_reg(OFS_DMA_CTRL, 32'h4);
                dma_busy = 1'b0;
                read_reg(OFS_DMA_CTRL);
                finish_test(5, "dma control", e0);

                e0 = errs;
                write_read_same(OFS_DIMS_M, $urandom);
                read_reg(OFS_DIMS_M);
                write_read_same(OFS_SCALE_W, $urandom);
                read_reg(OFS_SCALE_W);
                finish_test(6, "same-cycle read and write", e0);

                repeat (2) @(negedge clk_gated);
                $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
                if (fail_cnt == 0 && errs == 0) begin
                        $display("** PASS **");
                end else begin
                        $display("** FAIL **");
                end
                $finish;
        end

endmodule

/* flist.f */
design/accel_csr_pkg.sv
design/csr_addr_decode.sv
design/core_ctrl_regs.sv
design/dma_ctrl_regs.sv
design/csr_read_mux.sv
design/accel_csr_top.sv
sim/tb_clock_gen.sv
sim/tb_accel_csr.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CSR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_accel_csr -f flist.f -o tb_sim

out=$(./obj_dir/tb_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
        exit 0
else
        exit 1
fi
